//--- Bender.yml
package:
  name: decode_stage

sources:
  - rtl/decode_pkg.sv
  - rtl/imm_decoder.sv
  - rtl/uop_decoder.sv
  - rtl/pc_tracker.sv
  - rtl/decode_stage.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_decode_stage.sv

//--- rtl/decode_pkg.sv
// Shared widths and types for the RV32I decode stage
// Major opcodes, register and SYSTEM instruction constants, reset PC
// Micro-operation encodings for ALU, CFU, LSU and writeback select

`default_nettype none

package decode_pkg;

    // ----------------------------------------------------------------------
    // Widths and basic types
    // ----------------------------------------------------------------------

    localparam int XLEN       = 32;               // Data and address width
    localparam int REG_ADDR_W = 5;                // 32 integer registers

    typedef logic [XLEN-1:0]       word_t;        // Data or address value
    typedef logic [31:0]           instr_t;       // Raw instruction word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;    // Register index

    localparam reg_addr_t REG_ZERO = 5'd0;        // x0, hardwired zero

    // ----------------------------------------------------------------------
    // Major opcodes, instr[6:0]
    // ----------------------------------------------------------------------

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0] F7_BASE = 7'h00;       // Normal funct7
    localparam logic [6:0] F7_ALT  = 7'h20;       // SUB / SRA / SRAI

    // The only SYSTEM words this core accepts, matched as a whole
    localparam instr_t INSTR_ECALL  = 32'h0000_0073;
    localparam instr_t INSTR_EBREAK = 32'h0010_0073;
    localparam instr_t INSTR_MRET   = 32'h3020_0073;

    // ----------------------------------------------------------------------
    // Program counter
    // ----------------------------------------------------------------------

    localparam word_t PC_RESET_ADDR = 32'h1000_0000; // First fetch address
    localparam word_t INSTR_BYTES   = 32'd4;         // No compressed support

    // ----------------------------------------------------------------------
    // Micro-operation encodings
    // ----------------------------------------------------------------------

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [3:0] {
        CFU_NONE, CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU,
        CFU_JAL, CFU_JALR, CFU_ECALL, CFU_EBREAK, CFU_MRET
    } cfu_op_t;

    typedef enum logic [1:0] {
        LSU_BYTE, LSU_HALF, LSU_WORD
    } lsu_size_t;

    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_LSU, WB_NPC
    } wb_sel_t;

endpackage

`default_nettype wire

//--- rtl/decode_stage.sv
// Decode and operand gather stage, RV32I
// Fetch and execute handshakes, trap generation, ALU operand muxes
// Instantiates the immediate decoder, uop decoder and PC tracker

`timescale 1ns/100ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  wire            g_clk,                 // Global clock
    input  wire            g_resetn,              // Sync reset, active low

    input  wire            instr_valid_i,         // Fetch has an instruction
    input  wire instr_t    instr_i,               // Instruction word
    input  wire            fetch_err_i,           // Fetch bus error
    output logic           eat_o,                 // Instruction consumed

    input  wire            s2_ready_i,            // Execute can accept
    input  wire            cf_valid_i,            // Control flow change
    input  wire            cf_ack_i,              // Acked by fetch
    input  wire word_t     cf_target_i,           // Redirect destination

    output reg_addr_t      rs1_addr_o,            // Register file read port 1
    input  wire word_t     rs1_data_i,
    output reg_addr_t      rs2_addr_o,            // Register file read port 2
    input  wire word_t     rs2_data_i,

    output logic           s2_valid_o,            // Execute side valid
    output word_t          s2_pc_o,
    output word_t          s2_npc_o,
    output instr_t         s2_instr_o,
    output reg_addr_t      s2_rd_o,
    output word_t          s2_imm_o,
    output word_t          s2_rs1_data_o,
    output word_t          s2_rs2_data_o,
    output word_t          s2_alu_lhs_o,
    output word_t          s2_alu_rhs_o,
    output alu_op_t        s2_alu_op_o,
    output cfu_op_t        s2_cfu_op_o,
    output logic           s2_lsu_load_o,
    output logic           s2_lsu_store_o,
    output lsu_size_t      s2_lsu_size_o,
    output logic           s2_lsu_sext_o,
    output wb_sel_t        s2_wb_sel_o,
    output logic           s2_trap_o              // Illegal or fetch error
);

    logic alu_lhs_pc;
    logic alu_rhs_imm;
    logic illegal;

    // ----------------------------------------------------------------------
    // Handshakes and pass-through data
    // ----------------------------------------------------------------------

    assign eat_o      = instr_valid_i && s2_ready_i;
    assign s2_valid_o = instr_valid_i;

    assign s2_instr_o    = instr_i;
    assign s2_rs1_data_o = rs1_data_i;            // Already forwarded
    assign s2_rs2_data_o = rs2_data_i;

    assign s2_trap_o = illegal || fetch_err_i;

    // ALU operand select
    assign s2_alu_lhs_o = alu_lhs_pc  ? s2_pc_o  : rs1_data_i;
    assign s2_alu_rhs_o = alu_rhs_imm ? s2_imm_o : rs2_data_i;

    // ----------------------------------------------------------------------
    // Submodules
    // ----------------------------------------------------------------------

    imm_decoder i_imm_decoder (
        .instr_i       (instr_i),
        .imm_o         (s2_imm_o)
    );

    uop_decoder i_uop_decoder (
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr_o),
        .rs2_addr_o    (rs2_addr_o),
        .rd_o          (s2_rd_o),
        .alu_op_o      (s2_alu_op_o),
        .alu_lhs_pc_o  (alu_lhs_pc),
        .alu_rhs_imm_o (alu_rhs_imm),
        .cfu_op_o      (s2_cfu_op_o),
        .lsu_load_o    (s2_lsu_load_o),
        .lsu_store_o   (s2_lsu_store_o),
        .lsu_size_o    (s2_lsu_size_o),
        .lsu_sext_o    (s2_lsu_sext_o),
        .wb_sel_o      (s2_wb_sel_o),
        .illegal_o     (illegal)
    );

    pc_tracker i_pc_tracker (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .advance_i     (eat_o),                   // PC moves with fetch
        .cf_valid_i    (cf_valid_i),
        .cf_ack_i      (cf_ack_i),
        .cf_target_i   (cf_target_i),
        .pc_o          (s2_pc_o),
        .npc_o         (s2_npc_o)
    );

endmodule

`default_nettype wire

//--- rtl/imm_decoder.sv
// Immediate decoder for RV32I
// Builds the I, S, B, U and J immediates and the shift amount,
// picks one by major opcode

`timescale 1ns/100ps
`default_nettype none

module imm_decoder import decode_pkg::*; (
    input  wire instr_t instr_i,                  // Instruction to decode
    output word_t       imm_o                     // Sign-extended immediate
);

    logic [6:0] opcode;
    logic       shift_imm;                        // SLLI / SRLI / SRAI
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_shamt;

    assign opcode    = instr_i[6:0];
    assign shift_imm = (instr_i[13:12] == 2'b01); // funct3 001 or 101

    // ----------------------------------------------------------------------
    // Format immediates, all sign-extended from bit 31
    // ----------------------------------------------------------------------

    assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

    assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

    assign imm_b = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};

    assign imm_u = {instr_i[31:12], 12'b0};       // Low 12 bits cleared

    assign imm_j = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    assign imm_shamt = {{(XLEN-5){1'b0}}, instr_i[24:20]}; // Zero-extended

    // ----------------------------------------------------------------------
    // Format select
    // ----------------------------------------------------------------------

    always_comb begin
        case (opcode)
            OPC_OP_IMM: begin
                if (shift_imm) begin
                    imm_o = imm_shamt;            // funct7 sits above shamt
                end else begin
                    imm_o = imm_i;
                end
            end
            OPC_JALR,
            OPC_LOAD:   imm_o = imm_i;
            OPC_STORE:  imm_o = imm_s;
            OPC_BRANCH: imm_o = imm_b;
            OPC_LUI,
            OPC_AUIPC:  imm_o = imm_u;
            OPC_JAL:    imm_o = imm_j;
            default:    imm_o = '0;               // No immediate
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/pc_tracker.sv
// Program counter register for the decode stage
// Reset address, redirect on acknowledged control flow change,
// in-order advance and next PC

`timescale 1ns/100ps
`default_nettype none

module pc_tracker import decode_pkg::*; (
    input  wire        g_clk,                     // Global clock
    input  wire        g_resetn,                  // Sync reset, active low
    input  wire        advance_i,                 // Instruction consumed
    input  wire        cf_valid_i,                // Control flow change
    input  wire        cf_ack_i,                  // Change accepted by fetch
    input  wire word_t cf_target_i,               // Redirect destination
    output word_t      pc_o,                      // PC of current instr
    output word_t      npc_o                      // PC of following instr
);

    word_t pc_q;
    logic  redirect;

    assign redirect = cf_valid_i && cf_ack_i;

    assign npc_o = pc_q + INSTR_BYTES;
    assign pc_o  = pc_q;

    // Redirect wins over advance
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDR;
        end else if (redirect) begin
            pc_q <= cf_target_i;
        end else if (advance_i) begin
            pc_q <= npc_o;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uop_decoder.sv
// Micro-operation decoder for RV32I
// Register addresses, ALU / CFU / LSU operations, operand selects,
// writeback select and illegal instruction detection

`timescale 1ns/100ps
`default_nettype none

module uop_decoder import decode_pkg::*; (
    input  wire instr_t instr_i,                  // Instruction to decode
    output reg_addr_t   rs1_addr_o,               // Source register 1
    output reg_addr_t   rs2_addr_o,               // Source register 2
    output reg_addr_t   rd_o,                     // Destination register
    output alu_op_t     alu_op_o,                 // ALU operation
    output logic        alu_lhs_pc_o,             // Left operand is PC
    output logic        alu_rhs_imm_o,            // Right operand is imm
    output cfu_op_t     cfu_op_o,                 // Control flow operation
    output logic        lsu_load_o,               // Memory read
    output logic        lsu_store_o,              // Memory write
    output lsu_size_t   lsu_size_o,               // Access width
    output logic        lsu_sext_o,               // Sign-extend load data
    output wb_sel_t     wb_sel_o,                 // Writeback source
    output logic        illegal_o                 // Unsupported encoding
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_allowed;                      // funct7 0x20 may appear
    logic       funct7_ok;
    logic       shift_imm;
    alu_op_t    funct_op;                         // Op from funct fields
    lsu_size_t  mem_size;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ----------------------------------------------------------------------
    // Field checks and funct-selected operations
    // ----------------------------------------------------------------------

    assign alt_allowed = (funct3 == 3'b101) ||
                         (funct3 == 3'b000 && opcode == OPC_OP);
    assign funct7_ok   = (funct7 == F7_BASE) ||
                         (funct7 == F7_ALT && alt_allowed);
    assign shift_imm   = (funct3[1:0] == 2'b01);

    always_comb begin
        case (funct3)
            3'b000:  funct_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b011:  funct_op = ALU_SLTU;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  funct_op = ALU_OR;
            default: funct_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   mem_size = LSU_BYTE;
            2'b01:   mem_size = LSU_HALF;
            default: mem_size = LSU_WORD;         // 11 is flagged below
        endcase
    end

    // ----------------------------------------------------------------------
    // Main decode
    // ----------------------------------------------------------------------

    always_comb begin
        rs1_addr_o    = instr_i[19:15];
        rs2_addr_o    = instr_i[24:20];
        rd_o          = instr_i[11:7];
        alu_op_o      = ALU_NONE;
        alu_lhs_pc_o  = 1'b0;
        alu_rhs_imm_o = 1'b0;
        cfu_op_o      = CFU_NONE;
        lsu_load_o    = 1'b0;
        lsu_store_o   = 1'b0;
        lsu_size_o    = LSU_BYTE;
        lsu_sext_o    = 1'b0;
        wb_sel_o      = WB_NONE;
        illegal_o     = 1'b0;
        case (opcode)
            OPC_LUI: begin
                rs1_addr_o    = REG_ZERO;         // x0 + imm
                alu_op_o      = ALU_ADD;
                alu_rhs_imm_o = 1'b1;
                wb_sel_o      = WB_ALU;
            end
            OPC_AUIPC: begin
                alu_op_o      = ALU_ADD;
                alu_lhs_pc_o  = 1'b1;             // PC + imm
                alu_rhs_imm_o = 1'b1;
                wb_sel_o      = WB_ALU;
            end
            OPC_JAL: begin
                cfu_op_o      = CFU_JAL;
                wb_sel_o      = WB_NPC;           // Link address
            end
            OPC_JALR: begin
                alu_op_o      = ALU_ADD;          // rs1 + imm target
                alu_rhs_imm_o = 1'b1;
                cfu_op_o      = CFU_JALR;
                wb_sel_o      = WB_NPC;
            end
            OPC_BRANCH: begin
                rd_o          = REG_ZERO;
                alu_op_o      = ALU_SUB;          // Compare by subtraction
                case (funct3)
                    3'b000:  cfu_op_o = CFU_BEQ;
                    3'b001:  cfu_op_o = CFU_BNE;
                    3'b100:  cfu_op_o = CFU_BLT;
                    3'b101:  cfu_op_o = CFU_BGE;
                    3'b110:  cfu_op_o = CFU_BLTU;
                    3'b111:  cfu_op_o = CFU_BGEU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                alu_op_o      = ALU_ADD;          // Address generation
                alu_rhs_imm_o = 1'b1;
                lsu_load_o    = 1'b1;
                lsu_size_o    = mem_size;
                lsu_sext_o    = !funct3[2];       // LB / LH / LW
                wb_sel_o      = WB_LSU;
                illegal_o     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                rd_o          = REG_ZERO;
                alu_op_o      = ALU_ADD;
                alu_rhs_imm_o = 1'b1;
                lsu_store_o   = 1'b1;
                lsu_size_o    = mem_size;
                illegal_o     = funct3[2] || (funct3[1:0] == 2'b11);
            end
            OPC_OP_IMM: begin
                alu_op_o      = funct_op;
                alu_rhs_imm_o = 1'b1;
                wb_sel_o      = WB_ALU;
                illegal_o     = shift_imm && !funct7_ok; // Only shifts carry funct7
            end
            OPC_OP: begin
                alu_op_o      = funct_op;
                wb_sel_o      = WB_ALU;
                illegal_o     = !funct7_ok;
            end
            OPC_SYSTEM: begin
                rd_o          = REG_ZERO;
                case (instr_i)
                    INSTR_ECALL:  cfu_op_o = CFU_ECALL;
                    INSTR_EBREAK: cfu_op_o = CFU_EBREAK;
                    INSTR_MRET:   cfu_op_o = CFU_MRET;
                    default:      illegal_o = 1'b1; // CSR ops not supported
                endcase
            end
            default: begin
                illegal_o     = 1'b1;             // Unknown opcode
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verif/decode_model.svh
// Reference model for the RV32I decode stage testbench
// Galois LFSR, random instruction generator, expected immediate and uops

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'd73915;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state;

// Expected decode results for one instruction word
typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    alu_op_t   alu_op;
    logic      lhs_pc;
    logic      rhs_imm;
    cfu_op_t   cfu_op;
    logic      load;
    logic      store;
    lsu_size_t size;
    logic      sext;
    wb_sel_t   wb;
    logic      illegal;
} uop_exp_t;

// ----------------------------------------------------------------------
// Random numbers
// ----------------------------------------------------------------------

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ LFSR_TAPS;
    end else begin
        return s >> 1;
    end
endfunction

// One LFSR step per bit handed out
function automatic logic [31:0] rand_bits(input int unsigned count);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned k = 0; k < count; k++) begin
        bits       = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
endfunction

function automatic instr_t gen_instr();
    instr_t     w;
    logic [4:0] pick;
    logic [1:0] form;
    w    = rand_bits(32);
    pick = 5'(rand_bits(5));
    form = 2'(rand_bits(2));
    if (pick < 5'd30) begin
        case (pick % 5'd10)
            5'd0:    w[6:0] = OPC_LUI;
            5'd1:    w[6:0] = OPC_AUIPC;
            5'd2:    w[6:0] = OPC_JAL;
            5'd3:    w[6:0] = OPC_JALR;
            5'd4:    w[6:0] = OPC_BRANCH;
            5'd5:    w[6:0] = OPC_LOAD;
            5'd6:    w[6:0] = OPC_STORE;
            5'd7:    w[6:0] = OPC_OP_IMM;
            5'd8:    w[6:0] = OPC_OP;
            default: w[6:0] = OPC_SYSTEM;
        endcase
    end else begin
        w[6:0] = 7'(rand_bits(7));                // Mostly unknown opcodes
    end
    if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
        if (form == 2'd0) begin
            w[31:25] = 7'h00;
        end else if (form == 2'd1) begin
            w[31:25] = 7'h20;
        end
    end else if (w[6:0] == OPC_SYSTEM && form != 2'd3) begin
        w = (form == 2'd0) ? INSTR_ECALL : (form == 2'd1) ? INSTR_EBREAK : INSTR_MRET;
    end
    return w;
endfunction

// ----------------------------------------------------------------------
// Expected values
// ----------------------------------------------------------------------

function automatic word_t model_imm(input instr_t w);
    logic shamt_form;
    shamt_form = (w[14:12] == 3'b001) || (w[14:12] == 3'b101);
    case (w[6:0])
        OPC_OP_IMM: begin
            if (shamt_form) begin
                return {27'd0, w[24:20]};         // Shift amount only
            end else begin
                return 32'($signed(w[31:20]));
            end
        end
        OPC_JALR,
        OPC_LOAD:   return 32'($signed(w[31:20]));
        OPC_STORE:  return 32'($signed({w[31:25], w[11:7]}));
        OPC_BRANCH: return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        OPC_LUI,
        OPC_AUIPC:  return {w[31:12], 12'h000};
        OPC_JAL:    return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        default:    return '0;
    endcase
endfunction

function automatic alu_op_t model_alu(input logic is_op, input logic [2:0] f3,
                                      input logic alt);
    case (f3)
        3'd0:    return (is_op && alt) ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic uop_exp_t model_uop(input instr_t w);
    uop_exp_t   e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       f7_legal;
    opc      = w[6:0];
    f3       = w[14:12];
    f7_legal = (w[31:25] == 7'h00) ||
               (w[31:25] == 7'h20 && (f3 == 3'd5 || (opc == OPC_OP && f3 == 3'd0)));
    e         = '0;
    e.rs1     = w[19:15];
    e.rs2     = w[24:20];
    e.rd      = w[11:7];
    e.alu_op  = ALU_NONE;
    e.cfu_op  = CFU_NONE;
    e.size    = LSU_BYTE;
    e.wb      = WB_NONE;
    case (opc)
        OPC_LUI: begin
            e.rs1     = REG_ZERO;
            e.alu_op  = ALU_ADD;
            e.rhs_imm = 1'b1;
            e.wb      = WB_ALU;
        end
        OPC_AUIPC: begin
            e.alu_op  = ALU_ADD;
            e.lhs_pc  = 1'b1;
            e.rhs_imm = 1'b1;
            e.wb      = WB_ALU;
        end
        OPC_JAL: begin
            e.cfu_op  = CFU_JAL;
            e.wb      = WB_NPC;
        end
        OPC_JALR: begin
            e.alu_op  = ALU_ADD;
            e.rhs_imm = 1'b1;
            e.cfu_op  = CFU_JALR;
            e.wb      = WB_NPC;
        end
        OPC_BRANCH: begin
            e.rd      = REG_ZERO;
            e.alu_op  = ALU_SUB;
            case (f3)
                3'd0:    e.cfu_op = CFU_BEQ;
                3'd1:    e.cfu_op = CFU_BNE;
                3'd4:    e.cfu_op = CFU_BLT;
                3'd5:    e.cfu_op = CFU_BGE;
                3'd6:    e.cfu_op = CFU_BLTU;
                3'd7:    e.cfu_op = CFU_BGEU;
                default: e.illegal = 1'b1;        // funct3 2 and 3
            endcase
        end
        OPC_LOAD, OPC_STORE: begin
            e.rd      = (opc == OPC_STORE) ? REG_ZERO : w[11:7];
            e.alu_op  = ALU_ADD;
            e.rhs_imm = 1'b1;
            e.load    = (opc == OPC_LOAD);
            e.store   = (opc == OPC_STORE);
            e.size    = (f3[1:0] == 2'd0) ? LSU_BYTE : (f3[1:0] == 2'd1) ? LSU_HALF : LSU_WORD;
            e.sext    = e.load && !f3[2];         // LB, LH, LW
            e.wb      = e.load ? WB_LSU : WB_NONE;
            e.illegal = (f3[1:0] == 2'd3) || (f3[2] && (e.store || f3[1]));
        end
        OPC_OP_IMM: begin
            e.alu_op  = model_alu(1'b0, f3, w[30]);
            e.rhs_imm = 1'b1;
            e.wb      = WB_ALU;
            e.illegal = (f3 == 3'd1 || f3 == 3'd5) && !f7_legal;
        end
        OPC_OP: begin
            e.alu_op  = model_alu(1'b1, f3, w[30]);
            e.wb      = WB_ALU;
            e.illegal = !f7_legal;
        end
        OPC_SYSTEM: begin
            e.rd      = REG_ZERO;
            e.cfu_op  = (w == INSTR_ECALL) ? CFU_ECALL : (w == INSTR_EBREAK) ? CFU_EBREAK :
                        (w == INSTR_MRET) ? CFU_MRET : CFU_NONE;
            e.illegal = (e.cfu_op == CFU_NONE);
        end
        default: e.illegal = 1'b1;
    endcase
    return e;
endfunction

`endif

//--- verif/tb_decode_stage.sv
// Testbench for the RV32I decode stage
// Random instruction stream and handshakes, checked each cycle against a model

`timescale 1ns/100ps
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();

    localparam int NUM_TESTS      = 2000;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS + 100;

    logic      g_clk;
    logic      g_resetn;
    logic      instr_valid;
    instr_t    instr;
    logic      fetch_err;
    logic      s2_ready;
    logic      cf_valid;
    logic      cf_ack;
    word_t     cf_target;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      eat;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      s2_valid;
    word_t     s2_pc;
    word_t     s2_npc;
    instr_t    s2_instr;
    reg_addr_t s2_rd;
    word_t     s2_imm;
    word_t     s2_rs1_data;
    word_t     s2_rs2_data;
    word_t     s2_alu_lhs;
    word_t     s2_alu_rhs;
    alu_op_t   s2_alu_op;
    cfu_op_t   s2_cfu_op;
    logic      s2_lsu_load;
    logic      s2_lsu_store;
    lsu_size_t s2_lsu_size;
    logic      s2_lsu_sext;
    wb_sel_t   s2_wb_sel;
    logic      s2_trap;

    word_t     model_pc;                          // PC kept by the testbench
    int        cycle_count = 0;

    `include "decode_model.svh"

    decode_stage i_decode_stage (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .fetch_err_i    (fetch_err),
        .eat_o          (eat),
        .s2_ready_i     (s2_ready),
        .cf_valid_i     (cf_valid),
        .cf_ack_i       (cf_ack),
        .cf_target_i    (cf_target),
        .rs1_addr_o     (rs1_addr),
        .rs1_data_i     (rs1_data),
        .rs2_addr_o     (rs2_addr),
        .rs2_data_i     (rs2_data),
        .s2_valid_o     (s2_valid),
        .s2_pc_o        (s2_pc),
        .s2_npc_o       (s2_npc),
        .s2_instr_o     (s2_instr),
        .s2_rd_o        (s2_rd),
        .s2_imm_o       (s2_imm),
        .s2_rs1_data_o  (s2_rs1_data),
        .s2_rs2_data_o  (s2_rs2_data),
        .s2_alu_lhs_o   (s2_alu_lhs),
        .s2_alu_rhs_o   (s2_alu_rhs),
        .s2_alu_op_o    (s2_alu_op),
        .s2_cfu_op_o    (s2_cfu_op),
        .s2_lsu_load_o  (s2_lsu_load),
        .s2_lsu_store_o (s2_lsu_store),
        .s2_lsu_size_o  (s2_lsu_size),
        .s2_lsu_sext_o  (s2_lsu_sext),
        .s2_wb_sel_o    (s2_wb_sel),
        .s2_trap_o      (s2_trap)
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;                // 8 ns period
    end

    // ----------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected x%0d actual x%0d", name, exp, act));
        end
    endtask

    task automatic check_alu(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %s actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_cfu(input string name, input cfu_op_t exp, input cfu_op_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %s actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_size(input string name, input lsu_size_t exp, input lsu_size_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %s actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_wb(input string name, input wb_sel_t exp, input wb_sel_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %s actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and per-cycle checks
    // ----------------------------------------------------------------------

    task automatic drive_stimulus();
        instr       <= gen_instr();
        instr_valid <= (2'(rand_bits(2)) != 2'd0);
        s2_ready    <= (2'(rand_bits(2)) != 2'd0);
        cf_valid    <= (2'(rand_bits(2)) == 2'd0); // Redirects are rare
        cf_ack      <= 1'(rand_bits(1));
        cf_target   <= {30'(rand_bits(30)), 2'b00};
        fetch_err   <= (3'(rand_bits(3)) == 3'd0);
        rs1_data    <= rand_bits(32);
        rs2_data    <= rand_bits(32);
    endtask

    task automatic check_outputs(input int n);
        uop_exp_t e;
        word_t    imm;
        string    t;
        e   = model_uop(instr);
        imm = model_imm(instr);
        t   = $sformatf("cycle %0d", n);
        check_bit({t, " eat"}, instr_valid && s2_ready, eat);
        check_bit({t, " s2_valid"}, instr_valid, s2_valid);
        check_word({t, " pc"}, model_pc, s2_pc);
        check_word({t, " npc"}, model_pc + INSTR_BYTES, s2_npc);
        check_word({t, " instr"}, instr, s2_instr);
        check_word({t, " imm"}, imm, s2_imm);
        check_reg({t, " rs1_addr"}, e.rs1, rs1_addr);
        check_reg({t, " rs2_addr"}, e.rs2, rs2_addr);
        check_reg({t, " rd"}, e.rd, s2_rd);
        check_word({t, " rs1_data"}, rs1_data, s2_rs1_data);
        check_word({t, " rs2_data"}, rs2_data, s2_rs2_data);
        check_word({t, " alu_lhs"}, e.lhs_pc ? model_pc : rs1_data, s2_alu_lhs);
        check_word({t, " alu_rhs"}, e.rhs_imm ? imm : rs2_data, s2_alu_rhs);
        check_alu({t, " alu_op"}, e.alu_op, s2_alu_op);
        check_cfu({t, " cfu_op"}, e.cfu_op, s2_cfu_op);
        check_bit({t, " lsu_load"}, e.load, s2_lsu_load);
        check_bit({t, " lsu_store"}, e.store, s2_lsu_store);
        check_size({t, " lsu_size"}, e.size, s2_lsu_size);
        check_bit({t, " lsu_sext"}, e.sext, s2_lsu_sext);
        check_wb({t, " wb_sel"}, e.wb, s2_wb_sel);
        check_bit({t, " trap"}, e.illegal || fetch_err, s2_trap);
    endtask

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the test loop did not finish within the cycle limit");
        end
    end

    initial begin
        g_resetn    = 1'b0;
        instr_valid = 1'b0;                       // Idle fetch during reset
        instr       = '0;
        fetch_err   = 1'b0;
        s2_ready    = 1'b0;
        cf_valid    = 1'b0;
        cf_ack      = 1'b0;
        cf_target   = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        lfsr_state  = LFSR_SEED;
        model_pc    = PC_RESET_ADDR;
        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_word("reset pc", PC_RESET_ADDR, s2_pc);
        check_word("reset npc", PC_RESET_ADDR + INSTR_BYTES, s2_npc);
        for (int n = 0; n < NUM_TESTS; n++) begin
            @(posedge g_clk);
            drive_stimulus();
            @(negedge g_clk);
            check_outputs(n);
            // PC seen by the DUT after the next edge, redirect first
            if (cf_valid && cf_ack) begin
                model_pc = cf_target;
            end else if (instr_valid && s2_ready) begin
                model_pc = model_pc + INSTR_BYTES;
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verif
rtl/decode_pkg.sv
rtl/imm_decoder.sv
rtl/uop_decoder.sv
rtl/pc_tracker.sv
rtl/decode_stage.sv
verif/tb_decode_stage.sv
